// File: src/nic_defines.svh
// ==============================
// Packet ring sizing
// Node count, packet age limit and per-node store depth
// ==============================

`ifndef NIC_DEFINES_SVH
`define NIC_DEFINES_SVH

// Processing nodes in the ring, ids 1 up to this value
// The 4-bit id field allows at most 14 nodes
`define RING_NODES 3

// Ager passes after which a packet is removed from the ring
`define AGE_MAX 6

// Words in each node store
`define MEM_WORDS 16

`endif

// File: src/nic_pkg.sv
// ==============================
// Packet ring types
// Opcodes, slot formats and node control encodings
// ==============================

package nic_pkg;

  // Opcode carried in every packet slot
  // PT_NULL must stay zero so that a cleared slot reads as empty
  typedef enum logic [2:0] {
    PT_NULL  = 3'd0,
    PT_WRITE = 3'd1,
    PT_READ  = 3'd2,
    PT_ACK   = 3'd3,
    PT_RDATA = 3'd4
  } pkt_type_e;

  // One packet slot, 51 bits
  typedef struct packed {
    pkt_type_e   typ;
    logic [3:0]  did;
    logic [3:0]  sid;
    logic [3:0]  age;
    logic [3:0]  addr;
    logic [31:0] data;
  } Packet;

  // One interrupt slot, empty while valid is low
  typedef struct packed {
    logic       valid;
    logic [3:0] sid;
  } IPacket;

  // Node controller states
  typedef enum logic [1:0] {ST_IDLE, ST_EXEC, ST_SEND} node_state_e;

  // What a node loads into its packet register
  typedef enum logic [1:0] {SEL_PASS, SEL_EMPTY, SEL_REPLY} slot_sel_e;

endpackage

// File: src/mem_if.sv
// ==============================
// Node store bus
// Write port and combinational read between controller and store
// ==============================

`timescale 1ns/10ps
`include "nic_defines.svh"

interface mem_if;

  logic                           we;
  logic [$clog2(`MEM_WORDS)-1:0]  addr;
  logic [31:0]                    wdata;
  logic [31:0]                    rdata;

  // The controller owns address and write data
  modport ctrl (output we, output addr, output wdata, input rdata);
  // The store only returns the addressed word
  modport mem (input we, input addr, input wdata, output rdata);

endinterface

// File: src/node_mem.sv
// ==============================
// Node word store
// 16 x 32 register file, clocked write and combinational read
// ==============================

`timescale 1ns/10ps
`include "nic_defines.svh"

module node_mem (
  input  logic clk_i,
  mem_if.mem   mem
);

  // Storage array
  logic [31:0] store_q [`MEM_WORDS];

  // Write lands at the end of the cycle in which the command is consumed
  always_ff @(posedge clk_i) begin
    if (mem.we) begin
      store_q[mem.addr] <= mem.wdata;
    end
  end

  // Read is asynchronous so the controller can latch the word
  // in the same cycle as it takes the command off the ring
  assign mem.rdata = store_q[mem.addr];

endmodule

// File: src/node_ctrl.sv
// ==============================
// Node controller
// Takes commands off the ring, runs them and queues the reply and interrupt
// ==============================

`timescale 1ns/10ps
`include "nic_defines.svh"

module node_ctrl (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic [3:0]         node_id_i,
  input  nic_pkg::Packet     packet_i,
  input  logic               slot_free_i,
  input  logic               islot_free_i,
  output nic_pkg::slot_sel_e sel_o,
  output nic_pkg::Packet     reply_o,
  output nic_pkg::IPacket    irq_o,
  mem_if.ctrl                mem
);

  import nic_pkg::*;

  node_state_e state_q;
  node_state_e state_d;
  logic        hit;
  logic        consume;
  logic        irq_pend_q;
  // Command fields kept for the reply
  logic        is_read_q;
  logic [3:0]  src_q;
  logic [3:0]  addr_q;
  logic [31:0] data_q;
  Packet       reply_q;

  // ==============================
  // Command decode
  // ==============================

  // A command addressed to this node
  assign hit = (packet_i.did == node_id_i) &&
               (packet_i.typ == PT_WRITE || packet_i.typ == PT_READ);
  // Only an idle node may take a command and otherwise it passes by
  assign consume = (state_q == ST_IDLE) && hit;

  // The store sees the passing packet and writes only when it is consumed
  assign mem.we    = consume && (packet_i.typ == PT_WRITE);
  assign mem.addr  = packet_i.addr;
  assign mem.wdata = packet_i.data;

  // ==============================
  // State machine
  // ==============================
  always_comb begin
    state_d = state_q;
    sel_o   = SEL_PASS;
    case (state_q)
      ST_IDLE: begin
        if (consume) begin
          sel_o   = SEL_EMPTY;
          state_d = ST_EXEC;
        end
      end
      // Reply is assembled during this state
      ST_EXEC: state_d = ST_SEND;
      ST_SEND: begin
        // Wait here for the first empty packet slot
        if (slot_free_i) begin
          sel_o   = SEL_REPLY;
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= ST_IDLE;
      irq_pend_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // Writing the last word signals the host and a new one wins over insertion
      if (mem.we && packet_i.addr == 4'(`MEM_WORDS - 1)) begin
        irq_pend_q <= 1'b1;
      end else if (irq_o.valid) begin
        irq_pend_q <= 1'b0;
      end
    end
  end

  // Command fields and read data are captured at consume
  always_ff @(posedge clk_i) begin
    if (consume) begin
      is_read_q <= (packet_i.typ == PT_READ);
      src_q     <= packet_i.sid;
      addr_q    <= packet_i.addr;
      data_q    <= (packet_i.typ == PT_READ) ? mem.rdata : packet_i.data;
    end
    if (state_q == ST_EXEC) begin
      if (is_read_q) begin
        reply_q.typ <= PT_RDATA;
      end else begin
        reply_q.typ <= PT_ACK;
      end
      reply_q.did  <= src_q;
      reply_q.sid  <= node_id_i;
      reply_q.age  <= 4'd0;
      reply_q.addr <= addr_q;
      reply_q.data <= data_q;
    end
  end

  assign reply_o = reply_q;

  // Interrupt goes out on any empty interrupt slot and apart from the packet path
  assign irq_o.valid = irq_pend_q && islot_free_i;
  assign irq_o.sid   = node_id_i;

  // ==============================
  // Checks
  // ==============================

  // ST_SEND is left only after a built reply took a slot that arrived empty
  a_send_exit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (state_q == ST_SEND) ##1 (state_q == ST_IDLE) |->
      $past(packet_i.typ == PT_NULL) && $past(sel_o == SEL_REPLY) &&
      $past(reply_o.typ == PT_ACK || reply_o.typ == PT_RDATA));

  // A command that meets a busy node passes on untouched and writes nothing
  a_consume_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (hit && state_q != ST_IDLE) |-> (sel_o == SEL_PASS) && !mem.we);

endmodule

// File: src/pnode.sv
// ==============================
// Ring node
// Slot registers around one controller and its word store
// ==============================

`timescale 1ns/10ps

module pnode (
  input  logic [3:0]      node_id_i,
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  nic_pkg::Packet  packet_i,
  output nic_pkg::Packet  packet_o,
  input  nic_pkg::IPacket ipacket_i,
  output nic_pkg::IPacket ipacket_o
);

  import nic_pkg::*;

  mem_if     mem_bus ();
  slot_sel_e sel;
  Packet     reply;
  IPacket    irq;
  logic      slot_free;
  logic      islot_free;
  Packet     packet_q;
  IPacket    ipacket_q;

  // Slot occupancy as seen at this node
  assign slot_free  = (packet_i.typ == PT_NULL);
  assign islot_free = !ipacket_i.valid;

  node_ctrl u_node_ctrl (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .node_id_i    (node_id_i),
    .packet_i     (packet_i),
    .slot_free_i  (slot_free),
    .islot_free_i (islot_free),
    .sel_o        (sel),
    .reply_o      (reply),
    .irq_o        (irq),
    .mem          (mem_bus)
  );

  node_mem u_node_mem (
    .clk_i (clk_i),
    .mem   (mem_bus)
  );

  // One register stage per slot, the controller picks the packet source
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      packet_q  <= '0;
      ipacket_q <= '0;
    end else begin
      case (sel)
        SEL_EMPTY: packet_q <= '0;
        SEL_REPLY: packet_q <= reply;
        default:   packet_q <= packet_i;
      endcase
      // Interrupt is only offered while the incoming slot is empty
      if (irq.valid) begin
        ipacket_q <= irq;
      end else begin
        ipacket_q <= ipacket_i;
      end
    end
  end

  assign packet_o  = packet_q;
  assign ipacket_o = ipacket_q;

endmodule

// File: src/nic_ager.sv
// ==============================
// Ring ager
// Counts passes per packet and removes stale ones
// ==============================

`timescale 1ns/10ps
`include "nic_defines.svh"

module nic_ager (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  nic_pkg::Packet  packet_i,
  output nic_pkg::Packet  packet_o,
  input  nic_pkg::IPacket ipacket_i,
  output nic_pkg::IPacket ipacket_o,
  output logic            drop_o
);

  import nic_pkg::*;

  logic [3:0] age_next;
  logic       expire;
  Packet      aged;
  Packet      packet_q;
  IPacket     ipacket_q;
  logic       drop_q;

  // Empty slots are not aged, they keep age zero
  assign age_next = packet_i.age + 4'd1;
  assign expire   = (packet_i.typ != PT_NULL) && (age_next >= 4'(`AGE_MAX));

  always_comb begin
    aged = packet_i;
    if (packet_i.typ != PT_NULL) begin
      aged.age = age_next;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      packet_q  <= '0;
      ipacket_q <= '0;
      drop_q    <= 1'b0;
    end else begin
      if (expire) begin
        packet_q <= '0;
      end else begin
        packet_q <= aged;
      end
      // Interrupts never age, they just pass one stage
      ipacket_q <= ipacket_i;
      drop_q    <= expire;
    end
  end

  assign packet_o  = packet_q;
  assign ipacket_o = ipacket_q;
  assign drop_o    = drop_q;

  // No packet leaving the ager is older than the limit
  a_age_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    packet_o.age <= 4'(`AGE_MAX));

endmodule

// File: src/node_ring.sv
// ==============================
// Node chain
// Processing nodes in series, closed by the ager stage
// ==============================

`timescale 1ns/10ps
`include "nic_defines.svh"

module node_ring (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  nic_pkg::Packet  packet_i,
  output nic_pkg::Packet  packet_o,
  input  nic_pkg::IPacket ipacket_i,
  output nic_pkg::IPacket ipacket_o,
  output logic            drop_o
);

  import nic_pkg::*;

  // Entry k feeds node k+1, the last entry feeds the ager
  Packet  pkt_chain  [`RING_NODES + 1];
  IPacket ipkt_chain [`RING_NODES + 1];

  // Node ids are 4 bits and 15 is kept free
  if (`RING_NODES > 14) begin : g_size_check
    $error("Ring holds more nodes than the id field allows");
  end

  assign pkt_chain[0]  = packet_i;
  assign ipkt_chain[0] = ipacket_i;

  for (genvar g = 0; g < `RING_NODES; g++) begin : g_node
    // Ids start at 1 since the host is node 0
    pnode u_pnode (
      .node_id_i (4'(g + 1)),
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .packet_i  (pkt_chain[g]),
      .packet_o  (pkt_chain[g + 1]),
      .ipacket_i (ipkt_chain[g]),
      .ipacket_o (ipkt_chain[g + 1])
    );
  end

  nic_ager u_nic_ager (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .packet_i  (pkt_chain[`RING_NODES]),
    .packet_o  (packet_o),
    .ipacket_i (ipkt_chain[`RING_NODES]),
    .ipacket_o (ipacket_o),
    .drop_o    (drop_o)
  );

endmodule

// File: src/host_nic.sv
// ==============================
// Host network interface
// Wishbone slave that sends commands and collects replies and interrupts
// ==============================

`timescale 1ns/10ps

module host_nic (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            wb_cyc_i,
  input  logic            wb_stb_i,
  input  logic            wb_we_i,
  input  logic [2:0]      wb_adr_i,
  input  logic [31:0]     wb_dat_i,
  output logic [31:0]     wb_dat_o,
  output logic            wb_ack_o,
  output logic            irq_o,
  output nic_pkg::Packet  packet_o,
  input  nic_pkg::Packet  packet_i,
  output nic_pkg::IPacket ipacket_o,
  input  nic_pkg::IPacket ipacket_i,
  input  logic            drop_i
);

  import nic_pkg::*;

  // Register word addresses
  localparam logic [2:0] REG_TX_CMD     = 3'd0;
  localparam logic [2:0] REG_TX_DATA    = 3'd1;
  localparam logic [2:0] REG_RX_DATA    = 3'd2;
  localparam logic [2:0] REG_RX_STATUS  = 3'd3;
  localparam logic [2:0] REG_DROP_COUNT = 3'd4;
  localparam logic [2:0] REG_IRQ_STATUS = 3'd5;

  logic        req;
  logic        cmd_wr;
  logic        simple_ack;
  logic        rd_req;
  logic        rx_take;
  logic        insert;
  logic        ack_q;
  logic [31:0] tx_data_q;
  logic        rx_valid_q;
  pkt_type_e   rx_typ_q;
  logic [3:0]  rx_sid_q;
  logic [3:0]  rx_addr_q;
  logic [31:0] rx_data_q;
  logic        irq_pend_q;
  logic [3:0]  irq_sid_q;
  logic [15:0] drop_cnt_q;
  logic [31:0] rd_data;
  logic [31:0] dat_q;
  Packet       cmd_pkt;
  Packet       packet_q;
  IPacket      ipacket_q;

  // ==============================
  // Bus decode
  // ==============================

  // Open cycle that has not been acknowledged yet
  assign req        = wb_cyc_i && wb_stb_i && !ack_q;
  assign cmd_wr     = req && wb_we_i && (wb_adr_i == REG_TX_CMD);
  // Everything but a command write finishes in one cycle
  assign simple_ack = req && !(wb_we_i && (wb_adr_i == REG_TX_CMD));
  assign rd_req     = simple_ack && !wb_we_i;

  // A reply for the host is taken only into an empty receive register
  assign rx_take = !rx_valid_q && (packet_i.did == 4'd0) &&
                   (packet_i.typ == PT_ACK || packet_i.typ == PT_RDATA);
  // The pending command enters an empty slot or one freed by a capture
  assign insert  = cmd_wr && ((packet_i.typ == PT_NULL) || rx_take);

  // Command built from the held bus word and the data register
  always_comb begin
    cmd_pkt      = '0;
    cmd_pkt.typ  = pkt_type_e'(wb_dat_i[6:4]);
    cmd_pkt.did  = wb_dat_i[3:0];
    cmd_pkt.addr = wb_dat_i[11:8];
    cmd_pkt.data = tx_data_q;
  end

  always_comb begin
    rd_data = '0;
    case (wb_adr_i)
      REG_RX_DATA:    rd_data = rx_data_q;
      REG_RX_STATUS:  rd_data = {20'd0, rx_addr_q, rx_sid_q, rx_typ_q, rx_valid_q};
      REG_DROP_COUNT: rd_data = {16'd0, drop_cnt_q};
      REG_IRQ_STATUS: rd_data = {24'd0, irq_sid_q, 3'd0, irq_pend_q};
      default:        rd_data = '0;
    endcase
  end

  // ==============================
  // State and slot registers
  // ==============================
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_q      <= 1'b0;
      rx_valid_q <= 1'b0;
      rx_typ_q   <= PT_NULL;
      rx_sid_q   <= 4'd0;
      rx_addr_q  <= 4'd0;
      rx_data_q  <= '0;
      irq_pend_q <= 1'b0;
      irq_sid_q  <= 4'd0;
      drop_cnt_q <= '0;
      packet_q   <= '0;
      ipacket_q  <= '0;
    end else begin
      ack_q <= simple_ack || insert;
      if (rx_take) begin
        rx_valid_q <= 1'b1;
        rx_typ_q   <= packet_i.typ;
        rx_sid_q   <= packet_i.sid;
        rx_addr_q  <= packet_i.addr;
        rx_data_q  <= packet_i.data;
      end else if (rd_req && wb_adr_i == REG_RX_DATA) begin
        rx_valid_q <= 1'b0;
      end
      // A fresh interrupt wins over a status read in the same cycle
      if (ipacket_i.valid) begin
        irq_pend_q <= 1'b1;
        irq_sid_q  <= ipacket_i.sid;
      end else if (rd_req && wb_adr_i == REG_IRQ_STATUS) begin
        irq_pend_q <= 1'b0;
      end
      if (drop_i) begin
        drop_cnt_q <= drop_cnt_q + 16'd1;
      end
      if (insert) begin
        packet_q <= cmd_pkt;
      end else if (rx_take) begin
        packet_q <= '0;
      end else begin
        packet_q <= packet_i;
      end
      // Every interrupt packet ends at the host
      if (ipacket_i.valid) begin
        ipacket_q <= '0;
      end else begin
        ipacket_q <= ipacket_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req && wb_we_i && wb_adr_i == REG_TX_DATA) begin
      tx_data_q <= wb_dat_i;
    end
    if (rd_req) begin
      dat_q <= rd_data;
    end
  end

  assign wb_ack_o  = ack_q;
  assign wb_dat_o  = dat_q;
  assign irq_o     = irq_pend_q;
  assign packet_o  = packet_q;
  assign ipacket_o = ipacket_q;

  // Each ack closes its cycle, the master must drop stb before the next one
  a_ack_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_ack_o |=> !wb_ack_o);

endmodule

// File: src/ring_top.sv
// ==============================
// Packet ring top level
// Host interface joined to the closed node ring
// ==============================

`timescale 1ns/10ps

module ring_top (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [2:0]  wb_adr_i,
  input  logic [31:0] wb_dat_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o,
  output logic        irq_o
);

  import nic_pkg::*;

  // Host to ring and ring back to host
  Packet  host_pkt;
  Packet  ring_pkt;
  IPacket host_ipkt;
  IPacket ring_ipkt;
  logic   drop;

  host_nic u_host_nic (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .wb_cyc_i  (wb_cyc_i),
    .wb_stb_i  (wb_stb_i),
    .wb_we_i   (wb_we_i),
    .wb_adr_i  (wb_adr_i),
    .wb_dat_i  (wb_dat_i),
    .wb_dat_o  (wb_dat_o),
    .wb_ack_o  (wb_ack_o),
    .irq_o     (irq_o),
    .packet_o  (host_pkt),
    .packet_i  (ring_pkt),
    .ipacket_o (host_ipkt),
    .ipacket_i (ring_ipkt),
    .drop_i    (drop)
  );

  node_ring u_node_ring (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .packet_i  (host_pkt),
    .packet_o  (ring_pkt),
    .ipacket_i (host_ipkt),
    .ipacket_o (ring_ipkt),
    .drop_o    (drop)
  );

endmodule

// File: dv/ring_tb.sv
// ==============================
// Packet ring testbench
// Wishbone traffic to every node, checked against a store model
// ==============================

`timescale 1ns/10ps
`include "nic_defines.svh"

module ring_tb;

  import nic_pkg::*;

  localparam int CLK_HALF = 10;
  // Register stages around the loop, host and ager included
  localparam int RING_LEN = `RING_NODES + 2;
  localparam int RAND_OPS = 8;
  // Node writes, random writes and reads, irq write and the lost command
  localparam int NUM_CMDS = `RING_NODES + 2 * RAND_OPS + 2;
  localparam int WATCHDOG_CYCLES = NUM_CMDS * (`AGE_MAX + 2) * RING_LEN * 40;

  logic        clk;
  logic        rst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [2:0]  wb_adr;
  logic [31:0] wb_dat;
  logic [31:0] wb_dat_o;
  logic        wb_ack_o;
  logic        irq_o;
  logic [31:0] rng_state = 32'd36;
  // Expected store contents, index 0 is the host and stays unused
  logic [31:0] model_mem [`RING_NODES + 1][`MEM_WORDS];
  // Words known to hold data, kept as node and word index
  logic [7:0]  written_q [$];

  ring_top ring_top_i (
    .clk_i    (clk),
    .rst_n_i  (rst_n),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .irq_o    (irq_o)
  );

  always #CLK_HALF clk = ~clk;

  // ==============================
  // Helpers
  // ==============================

  task automatic stop_failed();
    $display("Done: errors found");
    $fatal(1, "Simulation stopped at the first failed check");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
      stop_failed();
    end
  endtask

  // Linear congruential generator, the upper bits are the better ones
  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic int rand_below(input int n);
    return int'((next_rand() >> 8) % n);
  endfunction

  // Classic single cycle, outputs held until ack is seen on a falling edge
  task automatic wb_access(input logic we, input logic [2:0] adr,
                           input logic [31:0] dat_w, output logic [31:0] dat_r);
    @(negedge clk);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = we;
    wb_adr = adr;
    wb_dat = dat_w;
    do begin
      @(negedge clk);
    end while (!wb_ack_o);
    dat_r  = wb_dat_o;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input logic [2:0] adr, input logic [31:0] dat);
    logic [31:0] unused;
    wb_access(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input logic [2:0] adr, output logic [31:0] dat);
    wb_access(1'b0, adr, 32'd0, dat);
  endtask

  // TX_DATA first, the TX_CMD write then launches the packet
  task automatic send_cmd(input logic [3:0] did, input pkt_type_e typ,
                          input logic [3:0] addr, input logic [31:0] data);
    wb_write(3'd1, data);
    wb_write(3'd0, {20'd0, addr, 1'b0, typ, did});
  endtask

  // Poll RX_STATUS until a reply is held, then read and release RX_DATA
  task automatic wait_reply(output logic [31:0] status, output logic [31:0] data);
    status = '0;
    while (!status[0]) begin
      wb_read(3'd3, status);
    end
    wb_read(3'd2, data);
  endtask

  task automatic write_word(input logic [3:0] node, input logic [3:0] addr,
                            input logic [31:0] data);
    logic [31:0] status;
    logic [31:0] rdata;
    send_cmd(node, PT_WRITE, addr, data);
    wait_reply(status, rdata);
    check_value("RX_STATUS", status, {20'd0, addr, node, PT_ACK, 1'b1});
    model_mem[node][addr] = data;
    written_q.push_back({node, addr});
  endtask

  task automatic read_word(input logic [3:0] node, input logic [3:0] addr);
    logic [31:0] status;
    logic [31:0] rdata;
    send_cmd(node, PT_READ, addr, 32'd0);
    wait_reply(status, rdata);
    check_value("RX_STATUS", status, {20'd0, addr, node, PT_RDATA, 1'b1});
    check_value("RX_DATA", rdata, model_mem[node][addr]);
  endtask

  // ==============================
  // Bus protocol checks
  // ==============================

  a_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    wb_ack_o |=> !wb_ack_o) else begin
    $display("Error: wb_ack_o stayed high for two cycles");
    stop_failed();
  end

  // A register read is answered in the very next cycle
  a_read_ack: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_cyc && wb_stb && !wb_we && !wb_ack_o) |=> wb_ack_o) else begin
    $display("Error: wb_ack_o did not follow a register read after one cycle");
    stop_failed();
  end

  // Bound scales with the number of commands and the worst loop time
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    stop_failed();
  end

  // ==============================
  // Test sequence
  // ==============================
  initial begin
    logic [31:0] rdata;
    logic [31:0] drops_before;
    logic [3:0]  node;
    logic [7:0]  entry;
    clk    = 1'b0;
    rst_n  = 1'b0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    wb_adr = 3'd0;
    wb_dat = 32'd0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // Idle state after reset
    check_value("wb_ack_o", wb_ack_o, 1'b0);
    check_value("irq_o", irq_o, 1'b0);
    wb_read(3'd4, rdata);
    check_value("DROP_COUNT", rdata, 32'd0);
    wb_read(3'd3, rdata);
    check_value("RX_STATUS.valid", rdata[0], 1'b0);
    wb_read(3'd5, rdata);
    check_value("IRQ_STATUS.pending", rdata[0], 1'b0);

    // One write per node, word 15 is kept for the interrupt test
    for (int n = 1; n <= `RING_NODES; n++) begin
      write_word(4'(n), 4'(rand_below(15)), next_rand());
    end

    // Random writes, then random reads of words that hold data
    for (int i = 0; i < RAND_OPS; i++) begin
      write_word(4'(1 + rand_below(`RING_NODES)), 4'(rand_below(15)), next_rand());
    end
    for (int i = 0; i < RAND_OPS; i++) begin
      entry = written_q[rand_below(written_q.size())];
      read_word(entry[7:4], entry[3:0]);
    end

    // Last word of a node raises the host interrupt
    node = 4'(1 + rand_below(`RING_NODES));
    write_word(node, 4'(`MEM_WORDS - 1), next_rand());
    while (!irq_o) begin
      @(negedge clk);
    end
    wb_read(3'd5, rdata);
    check_value("IRQ_STATUS", rdata, {24'd0, node, 3'd0, 1'b1});
    wb_read(3'd5, rdata);
    check_value("IRQ_STATUS.pending", rdata[0], 1'b0);
    check_value("irq_o", irq_o, 1'b0);

    // No node answers id 9, so the command ages out exactly once
    wb_read(3'd4, drops_before);
    send_cmd(4'd9, PT_WRITE, 4'(rand_below(15)), next_rand());
    rdata = drops_before;
    while (rdata == drops_before) begin
      wb_read(3'd4, rdata);
    end
    check_value("DROP_COUNT", rdata, drops_before + 32'd1);
    repeat (RING_LEN * (`AGE_MAX + 2)) @(negedge clk);
    wb_read(3'd4, rdata);
    check_value("DROP_COUNT", rdata, drops_before + 32'd1);
    wb_read(3'd3, rdata);
    check_value("RX_STATUS.valid", rdata[0], 1'b0);

    $display("Done: no errors");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+src
src/nic_pkg.sv
src/mem_if.sv
src/node_mem.sv
src/node_ctrl.sv
src/pnode.sv
src/nic_ager.sv
src/node_ring.sv
src/host_nic.sv
src/ring_top.sv
dv/ring_tb.sv

// File: Bender.yml
package:
  name: packet_ring

sources:
  - include_dirs:
      - src
    files:
      - src/nic_pkg.sv
      - src/mem_if.sv
      - src/node_mem.sv
      - src/node_ctrl.sv
      - src/pnode.sv
      - src/nic_ager.sv
      - src/node_ring.sv
      - src/host_nic.sv
      - src/ring_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/ring_tb.sv
